//--- debug_pkg.sv
/* debug unit shared types */

package debug_pkg;

    // ----------------------------------------
    // scalar widths
    // ----------------------------------------
    typedef logic [31:0] addr_t;    // linear address / debug register value
    typedef logic [2:0]  bp_len_t;  // length mask: 000 001 011 111 -> 1 2 4 8 bytes
    typedef logic [2:0]  acc_len_t; // access length in bytes, 1..4
    typedef logic [3:0]  bp_vec_t;  // one bit per breakpoint

    // dr7 r/w field encoding
    typedef enum logic [1:0] {
        bp_exec  = 2'b00,  // instruction fetch
        bp_write = 2'b01,  // data write only
        bp_io    = 2'b10,  // i/o access, never matches here
        bp_rdwr  = 2'b11   // data read or write
    } bp_rw_e;

    // ----------------------------------------
    // per-breakpoint configuration
    // ----------------------------------------
    typedef struct packed {
        addr_t   addr;      // dr0..dr3
        bp_len_t len_mask;  // decoded from len field
        bp_rw_e  rw;
        logic    enabled;   // local or global enable
    } bp_cfg_t;

    typedef bp_cfg_t [3:0] bp_cfg_arr_t;

    // status record handed to exception entry
    typedef struct packed {
        bp_vec_t code;
        bp_vec_t write;
        bp_vec_t read;
        logic    step;     // single step
        logic    task_sw;  // task switch trap
    } dbg_status_t;

    // ----------------------------------------
    // range overlap of an access against one breakpoint
    // ----------------------------------------
    // the breakpoint covers its address aligned down to the length, up to
    // the same address with the masked bits all set
    function automatic logic bp_overlap(input bp_cfg_t cfg, input addr_t first,
                                        input addr_t last);
        addr_t lo;
        addr_t hi;
        lo = {cfg.addr[31:3], cfg.addr[2:0] & ~cfg.len_mask};  // first covered byte
        hi = {cfg.addr[31:3], cfg.addr[2:0] | cfg.len_mask};   // last covered byte
        bp_overlap = (first <= hi) && (last >= lo);
    endfunction

endpackage

//--- dbg_reg_decode.sv
/* debug registers and dr7 decode */

`timescale 1ns/1ps

module dbg_reg_decode import debug_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // register write port
    input  logic        dr_wr,        // one-cycle strobe
    input  logic [2:0]  dr_sel,       // 0..3 -> dr0..dr3, 7 -> dr7
    input  addr_t       dr_wdata,

    // decoded configuration
    output bp_cfg_arr_t bp_cfg,
    output logic        bps_disabled
);

    // ----------------------------------------
    // register file
    // ----------------------------------------
    addr_t [3:0] dr_q;   // breakpoint linear addresses
    addr_t       dr7_q;  // control register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dr_q  <= '0;
            dr7_q <= '0;
        end else if (dr_wr) begin
            if (dr_sel == 3'd7)
                dr7_q <= dr_wdata;
            else if (!dr_sel[2])
                dr_q[dr_sel[1:0]] <= dr_wdata;  // dr0..dr3
        end
    end

    // ----------------------------------------
    // field decode
    // ----------------------------------------
    // len field to byte mask, 10 is the 8-byte form
    function automatic bp_len_t len_to_mask(input logic [1:0] len);
        case (len)
            2'b00:   len_to_mask = 3'b000;  // 1 byte
            2'b01:   len_to_mask = 3'b001;  // 2 bytes
            2'b10:   len_to_mask = 3'b111;  // 8 bytes
            default: len_to_mask = 3'b011;  // 4 bytes
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            bp_cfg[i].addr     = dr_q[i];
            // dr7 layout per breakpoint: rw at 16+4i, len at 18+4i
            bp_cfg[i].rw       = bp_rw_e'(dr7_q[16 + 4*i +: 2]);
            bp_cfg[i].len_mask = len_to_mask(dr7_q[18 + 4*i +: 2]);
            // L at 2i, G at 2i+1
            bp_cfg[i].enabled  = |dr7_q[2*i +: 2];
        end
    end

    // no enable bit set at all
    assign bps_disabled = (dr7_q[7:0] == 8'h00);

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // the core only addresses dr0..dr3 and dr7 here
    a_dr_sel_legal : assert property (
        @(posedge clk) disable iff (!rst_n)
        dr_wr |-> (dr_sel <= 3'd3 || dr_sel == 3'd7)
    ) else $error("write to unsupported debug register %0d", dr_sel);

endmodule

//--- read_bp_match.sv
/* execute stage read matcher */

`timescale 1ns/1ps

module read_bp_match import debug_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // data read from execute
    input  logic        read_valid,
    input  addr_t       read_addr,
    input  acc_len_t    read_len,   // 1..4 bytes

    input  bp_cfg_arr_t bp_cfg,

    output bp_vec_t     exe_debug_read  // one cycle after read_valid
);

    // ----------------------------------------
    // access range
    // ----------------------------------------
    addr_t   read_last;   // last byte touched
    bp_vec_t read_hit;    // combinational per-breakpoint match

    assign read_last = read_addr + {29'd0, read_len} - 32'd1;

    // ----------------------------------------
    // per-breakpoint compare
    // ----------------------------------------
    // only r/w breakpoints see reads, write-only and exec never do.
    // enable bits are applied later in write-back
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            read_hit[i] = (bp_cfg[i].rw == bp_rdwr) &&
                          bp_overlap(bp_cfg[i], read_addr, read_last);
        end
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            exe_debug_read <= '0;
        else if (read_valid)
            exe_debug_read <= read_hit;  // handed to write-back with w_load
        else
            exe_debug_read <= '0;        // no read, no hit
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // write-back ORs this vector on w_load, so a stale hit after an idle
    // cycle would mark a breakpoint that no read touched
    a_no_stale_hit : assert property (
        @(posedge clk) disable iff (!rst_n)
        !read_valid |=> (exe_debug_read == '0)
    ) else $error("read hit without a read in the previous cycle");

endmodule

//--- debug_trap_collect.sv
/* write-back breakpoint and trap collector */

`timescale 1ns/1ps

module debug_trap_collect import debug_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // configuration
    input  bp_cfg_arr_t bp_cfg,
    input  logic        bps_disabled,

    // from execute
    input  bp_vec_t     exe_debug_read,

    // memory write
    input  addr_t       write_address,
    input  acc_len_t    write_length,
    input  logic        write_for_wr_ready,  // >= 2 cycles after a valid address

    // write-back control
    input  logic        w_load,
    input  logic        wr_finished,
    input  logic        inhibit,             // interrupts and debug held off
    input  logic        task_trigger,
    input  logic        trap_clear,
    input  logic        string_in_progress,
    input  logic        rflag,
    input  logic        tflag,

    // code address
    input  addr_t       wr_eip,
    input  addr_t       cs_base,
    input  addr_t       cs_limit,

    output logic        debug_prepare,
    output dbg_status_t debug_status
);

    bp_vec_t en_vec;      // breakpoints with L or G set

    always_comb begin
        for (int i = 0; i < 4; i++)
            en_vec[i] = bp_cfg[i].enabled;
    end

    // ----------------------------------------
    // write overlap pipeline
    // ----------------------------------------
    addr_t   write_first_q;   // stage 1, address
    addr_t   write_last_q;    // stage 1, last byte
    bp_vec_t write_match;
    bp_vec_t write_trig_q;    // stage 2, usable 2 cycles after address
    bp_vec_t write_cur;
    bp_vec_t write_q;         // accumulated write hits
    bp_vec_t write_hit;
    logic    write_active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_first_q <= '0;
            write_last_q  <= '0;
        end else begin
            write_first_q <= write_address;
            write_last_q  <= write_address + {29'd0, write_length} - 32'd1;
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            // rw of 01 or 11 watches writes
            write_match[i] = (bp_cfg[i].rw == bp_write || bp_cfg[i].rw == bp_rdwr) &&
                             bp_overlap(bp_cfg[i], write_first_q, write_last_q);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            write_trig_q <= '0;
        else
            write_trig_q <= write_match;
    end

    assign write_cur = bps_disabled ? '0 : write_trig_q;
    assign write_hit = write_cur | write_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            write_q <= '0;
        else if (inhibit)
            write_q <= write_q;                  // frozen
        else if (trap_clear)
            write_q <= '0;
        else if (write_for_wr_ready || debug_prepare)
            write_q <= write_hit;
        else if (wr_finished)
            write_q <= '0;                       // instruction done, no trap
    end

    assign write_active = |(write_hit & en_vec);

    // ----------------------------------------
    // read hit accumulator
    // ----------------------------------------
    bp_vec_t read_cur;
    bp_vec_t read_q;
    logic    read_active;

    assign read_cur = bps_disabled ? '0 : exe_debug_read;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            read_q <= '0;
        else if (inhibit || debug_prepare)
            read_q <= read_q;                    // held for the status record
        else if (trap_clear)
            read_q <= '0;
        else if (wr_finished && w_load)
            read_q <= read_cur;                  // last load of the instruction
        else if (wr_finished)
            read_q <= '0;
        else if (w_load)
            read_q <= read_q | read_cur;
    end

    assign read_active = |(read_q & en_vec);

    // ----------------------------------------
    // code breakpoints
    // ----------------------------------------
    addr_t   code_lin;
    logic    code_ok;
    bp_vec_t code_trig;
    logic    code_active;
    bp_vec_t code_vec;
    bp_vec_t code_q;

    assign code_lin = cs_base + wr_eip;
    assign code_ok  = wr_finished && (wr_eip <= cs_limit) && !rflag &&
                      !string_in_progress && !bps_disabled;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            // compare with the low bits under the length mask ignored
            code_trig[i] = code_ok && (bp_cfg[i].rw == bp_exec) &&
                           ({code_lin[31:3], code_lin[2:0] & ~bp_cfg[i].len_mask} ==
                            {bp_cfg[i].addr[31:3], bp_cfg[i].addr[2:0] & ~bp_cfg[i].len_mask});
        end
    end

    assign code_active = |(code_trig & en_vec);
    assign code_vec    = code_active ? code_trig : '0;

    // ----------------------------------------
    // single step, task switch, status
    // ----------------------------------------
    logic step_pend;   // tflag seen at last finished instruction
    logic step_q;
    logic task_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            step_pend <= 1'b0;
        else if (trap_clear)
            step_pend <= 1'b0;
        else if (wr_finished)
            step_pend <= tflag;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            code_q <= '0;
            step_q <= 1'b0;
            task_q <= 1'b0;
        end else if (debug_prepare) begin
            code_q <= code_vec;
            step_q <= step_pend;
            task_q <= task_trigger;
        end
    end

    assign debug_prepare = wr_finished && !inhibit &&
                           (task_trigger || step_pend || code_active ||
                            read_active || write_active);

    assign debug_status.code    = code_q;
    assign debug_status.write   = write_q;
    assign debug_status.read    = read_q;
    assign debug_status.step    = step_q;
    assign debug_status.task_sw = task_q;

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_prepare_at_finish : assert property (
        @(posedge clk) disable iff (!rst_n)
        debug_prepare |-> wr_finished
    ) else $error("debug_prepare outside wr_finished");

    // a new code record only appears after a prepare edge
    a_code_after_prepare : assert property (
        @(posedge clk) disable iff (!rst_n)
        (!$stable(debug_status.code) && debug_status.code != '0) |-> $past(debug_prepare)
    ) else $error("code status changed without debug_prepare");

endmodule

//--- debug_unit.sv
/* breakpoint and trap unit top */

`timescale 1ns/1ps

module debug_unit import debug_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // debug register writes
    input  logic        dr_wr,
    input  logic [2:0]  dr_sel,
    input  addr_t       dr_wdata,

    // execute stage read
    input  logic        read_valid,
    input  addr_t       read_addr,
    input  acc_len_t    read_len,

    // write-back stage
    input  addr_t       write_address,
    input  acc_len_t    write_length,
    input  logic        write_for_wr_ready,
    input  logic        w_load,
    input  logic        wr_finished,
    input  logic        inhibit,
    input  logic        task_trigger,
    input  logic        trap_clear,
    input  logic        string_in_progress,
    input  logic        rflag,
    input  logic        tflag,
    input  addr_t       wr_eip,
    input  addr_t       cs_base,
    input  addr_t       cs_limit,

    output logic        debug_prepare,
    output dbg_status_t debug_status
);

    bp_cfg_arr_t bp_cfg;          // decoded dr0..dr3 / dr7
    logic        bps_disabled;
    bp_vec_t     exe_debug_read;  // execute -> write-back

    dbg_reg_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .dr_wr        (dr_wr),
        .dr_sel       (dr_sel),
        .dr_wdata     (dr_wdata),
        .bp_cfg       (bp_cfg),
        .bps_disabled (bps_disabled)
    );

    read_bp_match u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .read_valid     (read_valid),
        .read_addr      (read_addr),
        .read_len       (read_len),
        .bp_cfg         (bp_cfg),
        .exe_debug_read (exe_debug_read)
    );

    debug_trap_collect u_result (
        .clk                (clk),
        .rst_n              (rst_n),
        .bp_cfg             (bp_cfg),
        .bps_disabled       (bps_disabled),
        .exe_debug_read     (exe_debug_read),
        .write_address      (write_address),
        .write_length       (write_length),
        .write_for_wr_ready (write_for_wr_ready),
        .w_load             (w_load),
        .wr_finished        (wr_finished),
        .inhibit            (inhibit),
        .task_trigger       (task_trigger),
        .trap_clear         (trap_clear),
        .string_in_progress (string_in_progress),
        .rflag              (rflag),
        .tflag              (tflag),
        .wr_eip             (wr_eip),
        .cs_base            (cs_base),
        .cs_limit           (cs_limit),
        .debug_prepare      (debug_prepare),
        .debug_status       (debug_status)
    );

endmodule

//--- tb_clock_gen.sv
/* testbench clock and reset */

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset low for the first 2 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- tb_debug_unit.sv
/* debug unit directed tests */

`timescale 1ns/1ps

module tb_debug_unit import debug_pkg::*; ();

    localparam int NUM_TESTS = 6;
    localparam int CYCLE_NS  = 4;

    logic        clk;
    logic        rst_n;
    logic        dr_wr;
    logic [2:0]  dr_sel;
    addr_t       dr_wdata;
    logic        read_valid;
    addr_t       read_addr;
    acc_len_t    read_len;
    addr_t       write_address;
    acc_len_t    write_length;
    logic        write_for_wr_ready, w_load, wr_finished, inhibit, task_trigger;
    logic        trap_clear, string_in_progress, rflag, tflag;
    addr_t       wr_eip, cs_base, cs_limit;
    logic        debug_prepare;
    dbg_status_t debug_status;

    integer seed = 32'h660c406a;
    int     errors = 0;
    int     errors_seen = 0;    // mismatches before the current test
    int     tests_passed = 0;
    int     tests_failed = 0;
    addr_t  bp_addr [4];        // addresses written to dr0..dr3

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    debug_unit DUT (.*);

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic set_idle();
        dr_wr              = 1'b0;
        dr_sel             = 3'd0;
        dr_wdata           = '0;
        read_valid         = 1'b0;
        read_addr          = '0;
        read_len           = 3'd1;
        write_address      = '0;
        write_length       = 3'd1;
        write_for_wr_ready = 1'b0;
        w_load             = 1'b0;
        wr_finished        = 1'b0;
        inhibit            = 1'b0;
        task_trigger       = 1'b0;
        trap_clear         = 1'b0;
        string_in_progress = 1'b0;
        rflag              = 1'b0;
        tflag              = 1'b0;
        wr_eip             = '0;
        cs_base            = '0;
        cs_limit           = 32'hffff_ffff;  // flat segment
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // dr7 value enabling one breakpoint locally
    function automatic addr_t dr7_entry(input int bp, input bp_rw_e rw, input logic [1:0] len);
        addr_t v;
        v = '0;
        v[2*bp] = 1'b1;
        v[16 + 4*bp +: 2] = rw;
        v[18 + 4*bp +: 2] = len;  // 00 1, 01 2, 11 4 bytes
        return v;
    endfunction

    task automatic write_reg(input logic [2:0] sel, input addr_t data);
        @(negedge clk);
        dr_wr    = 1'b1;
        dr_sel   = sel;
        dr_wdata = data;
        @(negedge clk);
        dr_wr    = 1'b0;
    endtask

    // address held, write ready once the trigger has settled
    task automatic write_access(input addr_t addr, input acc_len_t len);
        @(negedge clk);
        write_address = addr;
        write_length  = len;
        repeat (2) @(negedge clk);
        write_for_wr_ready = 1'b1;
        @(negedge clk);
        write_for_wr_ready = 1'b0;
    endtask

    // one instruction retires; prepare is checked in that cycle
    task automatic finish_instr(input logic exp_prep, input string what);
        @(negedge clk);
        wr_finished = 1'b1;
        #1;
        check_eq(32'(debug_prepare), 32'(exp_prep), what);
        @(negedge clk);
        wr_finished  = 1'b0;
        tflag        = 1'b0;
        task_trigger = 1'b0;
        inhibit      = 1'b0;
    endtask

    task automatic clear_traps();
        @(negedge clk);
        trap_clear = 1'b1;
        @(negedge clk);
        trap_clear = 1'b0;
    endtask

    // read in execute, then its last load retires in the next cycle
    task automatic read_then_load(input addr_t addr, input acc_len_t len);
        @(negedge clk);
        read_valid = 1'b1;
        read_addr  = addr;
        read_len   = len;
        @(negedge clk);
        read_valid  = 1'b0;
        w_load      = 1'b1;
        wr_finished = 1'b1;
        @(negedge clk);
        w_load      = 1'b0;
        wr_finished = 1'b0;
    endtask

    task automatic end_test(input string name);
        if (errors == errors_seen) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d mismatches", name, errors - errors_seen);
            tests_failed++;
        end
        errors_seen = errors;
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic idle_after_reset();
        #1;
        check_eq(32'(debug_prepare), 32'd0, "prepare after reset");
        check_eq(32'(debug_status), 32'd0, "status after reset");
        finish_instr(1'b0, "idle instruction");
        check_eq(32'(debug_status), 32'd0, "status after idle instruction");
        end_test("reset and idle");
    endtask

    task automatic code_breakpoint();
        bp_addr[0] = $random(seed);
        write_reg(3'd0, bp_addr[0]);
        write_reg(3'd7, dr7_entry(0, bp_exec, 2'b00));
        wr_eip  = 32'h0000_1234;
        cs_base = bp_addr[0] - wr_eip;       // linear address hits dr0
        finish_instr(1'b1, "code match prepare");
        check_eq(32'(debug_status.code), 32'h1, "code status");
        cs_limit = wr_eip - 32'd1;           // eip just past the limit
        finish_instr(1'b0, "code beyond cs_limit");
        cs_limit = 32'hffff_ffff;
        rflag    = 1'b1;
        finish_instr(1'b0, "code with rflag");
        rflag    = 1'b0;
        end_test("code breakpoint");
    endtask

    task automatic write_breakpoint();
        addr_t r;
        r = $random(seed);
        bp_addr[1] = {4'h8, r[27:2], 2'b00};
        write_reg(3'd1, bp_addr[1]);
        write_reg(3'd7, dr7_entry(1, bp_write, 2'b11));
        write_access(bp_addr[1] + 32'd3, 3'd2);  // covers the last byte
        finish_instr(1'b1, "write overlap prepare");
        check_eq(32'(debug_status.write), 32'h2, "write status");
        clear_traps();
        write_access(bp_addr[1] + 32'd4, 3'd2);  // first byte past range
        finish_instr(1'b0, "write past range");
        check_eq(32'(debug_status.write), 32'h0, "write status after miss");
        write_address = '0;
        end_test("write breakpoint");
    endtask

    task automatic read_breakpoint();
        addr_t r;
        r = $random(seed);
        bp_addr[2] = {4'h4, r[27:2], 2'b00};
        write_reg(3'd2, bp_addr[2]);
        write_reg(3'd7, dr7_entry(2, bp_rdwr, 2'b11));
        read_then_load(bp_addr[2] + 32'd1, 3'd2);
        check_eq(32'(debug_status.read), 32'h4, "read status");
        finish_instr(1'b1, "read hit prepare");
        check_eq(32'(debug_status.read), 32'h4, "read status held");
        clear_traps();
        read_then_load(bp_addr[2] + 32'd4, 3'd1);
        check_eq(32'(debug_status.read), 32'h0, "read outside range");
        finish_instr(1'b0, "no read prepare");
        end_test("read breakpoint");
    endtask

    task automatic step_and_task();
        write_reg(3'd7, 32'h0);
        tflag = 1'b1;
        finish_instr(1'b0, "instruction with tflag");
        finish_instr(1'b1, "single step prepare");
        check_eq(32'(debug_status.step), 32'h1, "step status");
        check_eq(32'(debug_status.task_sw), 32'h0, "task_sw after step");
        task_trigger = 1'b1;
        finish_instr(1'b1, "task switch prepare");
        check_eq(32'(debug_status.task_sw), 32'h1, "task_sw status");
        check_eq(32'(debug_status.step), 32'h0, "step after task switch");
        task_trigger = 1'b1;
        inhibit      = 1'b1;
        finish_instr(1'b0, "inhibited prepare");
        tflag = 1'b1;
        finish_instr(1'b0, "tflag before clear");
        clear_traps();
        finish_instr(1'b0, "step after trap_clear");
        end_test("step, task switch, inhibit, clear");
    endtask

    task automatic disabled_breakpoints();
        addr_t ca;
        addr_t wa;
        for (int i = 0; i < 4; i++) begin
            bp_addr[i] = $random(seed);
            write_reg(3'(i), bp_addr[i]);
        end
        // exec, write, r/w, write with all enables clear
        write_reg(3'd7, 32'h5FD0_0000);
        cs_base = '0;
        for (int i = 0; i < 20; i++) begin
            ca = (i % 2 == 0) ? bp_addr[0] : $random(seed);   // even: exact match
            wa = (i % 2 == 0) ? bp_addr[1 + (i / 2) % 3] : $random(seed);
            write_access(wa, 3'd4);
            wr_eip = ca;
            finish_instr(1'b0, "prepare with breakpoints disabled");
        end
        write_address = '0;
        end_test("disabled breakpoints");
    endtask

    // ----------------------------------------
    // sequence and watchdog
    // ----------------------------------------
    initial begin
        set_idle();
        @(posedge rst_n);
        idle_after_reset();
        code_breakpoint();
        write_breakpoint();
        read_breakpoint();
        step_and_task();
        disabled_breakpoints();
        $display("summary: %0d tests passed, %0d failed, %0d mismatches",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * CYCLE_NS);
        $display("watchdog: tests did not finish within %0d cycles", NUM_TESTS * 200);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- src.f
debug_pkg.sv
dbg_reg_decode.sv
read_bp_match.sv
debug_trap_collect.sv
debug_unit.sv
tb_clock_gen.sv
tb_debug_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_debug_unit
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := TESTBENCH PASSED

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
